//--- hw/dreq_params.svh
//////////////////////////////////////////////////////////////////////
// data-request controller parameters
// widths of event-window tags, serial offset and counters
//////////////////////////////////////////////////////////////////////

`ifndef DREQ_PARAMS_SVH
`define DREQ_PARAMS_SVH

// event-window tag as carried by heartbeat and fetch
`define EVENT_TAG_BITS 48

// offset written over slow controls, zero-extended to a tag
`define SERIAL_OFFSET_BITS 32

// wide protocol counters
`define CNT_BITS 32

// edge counters of the diagnostic block
`define DIAG_BITS 16

`endif

//--- hw/dreq_pkg.sv
//////////////////////////////////////////////////////////////////////
// data-request controller types
// protocol state, tag status pulses and grouped counter outputs
//////////////////////////////////////////////////////////////////////

`include "dreq_params.svh"

package dreq_pkg;

    // protocol states, LAST encoded as 2'b11
    typedef enum logic [1:0]
    {
        IDLE  = 2'b00,
        VALID = 2'b01,
        LAST  = 2'b11
    } datareq_state_e;

    // tag outcome pulses from the event FIFO controller
    typedef struct packed
    {
        logic tag_sent;
        logic tag_null;
        logic tag_done;
    } ew_status_t;

    // protocol counters, start count comes from the fetch path
    typedef struct packed
    {
        logic [`CNT_BITS-1:0] start_tag_cnt;
        logic [`CNT_BITS-1:0] tag_sent_cnt;
        logic [`CNT_BITS-1:0] tag_done_cnt;
        logic [`CNT_BITS-1:0] tag_null_cnt;
    } fetch_cnt_t;

    // offset latched at spill start plus its one-cycle valid flag
    typedef struct packed
    {
        logic                       valid;
        logic [`EVENT_TAG_BITS-1:0] ewtag_offset;
    } offset_t;

    // rising-edge counts of tag_valid and of the tag error flag
    typedef struct packed
    {
        logic [`DIAG_BITS-1:0] tag_valid_count;
        logic [`DIAG_BITS-1:0] tag_error_count;
    } diag_cnt_t;

endpackage

//--- hw/fetch_tag_ctrl.sv
//////////////////////////////////////////////////////////////////////
// tag fetch request
// raises tag_fetch on a prefetch or data request and holds it,
// with the requested tag, until the size store answers
//////////////////////////////////////////////////////////////////////

`include "dreq_params.svh"

module fetch_tag_ctrl
(
    input  logic                       dreqclk,
    input  logic                       resetn_dreqclk,

    // fetch seen on the link, either prefetch or data request
    input  logic                       start_fetch,
    input  logic [`EVENT_TAG_BITS-1:0] event_window_fetch,

    // answer from the size store
    input  logic                       tag_valid,

    // request towards the size store
    output logic                       tag_fetch,
    output logic [`EVENT_TAG_BITS-1:0] evt_tag_fetch,

    // number of fetches started since reset
    output logic [`CNT_BITS-1:0]       start_tag_cnt
);

    //////////////////////////////////////////////////////////////////////
    // request flag and fetch counter
    //////////////////////////////////////////////////////////////////////

    // a new fetch wins over a same-cycle answer, so the request stays up
    always_ff @(posedge dreqclk or negedge resetn_dreqclk)
    begin
        if (!resetn_dreqclk)
        begin
            tag_fetch     <= 1'b0;
            start_tag_cnt <= '0;
        end
        else
        begin
            if (start_fetch)
            begin
                tag_fetch     <= 1'b1;
                start_tag_cnt <= start_tag_cnt + `CNT_BITS'(1);
            end
            else if (tag_valid)
            begin
                // request served, drop it
                tag_fetch <= 1'b0;
            end
        end
    end

    // requested tag, only meaningful while tag_fetch is high
    always_ff @(posedge dreqclk)
    begin
        if (start_fetch)
        begin
            evt_tag_fetch <= event_window_fetch;
        end
    end

    // the request must not be withdrawn without an answer from the size store
    a_fetch_fall_on_valid : assert property (
        @(posedge dreqclk) disable iff (!resetn_dreqclk)
        $fell(tag_fetch) |-> $past(tag_valid)
    )
    else $error("tag_fetch dropped without tag_valid");

endmodule

//--- hw/datareq_fsm.sv
//////////////////////////////////////////////////////////////////////
// data-request protocol FSM
// buffers early tag_sent/tag_null pulses, raises data_ready,
// closes the request with a last_word pulse and counts outcomes
//////////////////////////////////////////////////////////////////////

`include "dreq_params.svh"

module datareq_fsm
(
    input  logic                           dreqclk,
    input  logic                           resetn_dreqclk,

    // start of a data request on the link
    input  logic                           event_start,

    // outcome pulses from the event FIFO controller
    input  dreq_pkg::ew_status_t           ew_status,

    // fetches started, compared against tags sent
    input  logic [`CNT_BITS-1:0]           start_tag_cnt,

    output logic                           data_ready,
    output logic                           last_word,
    output logic                           tag_error,
    output dreq_pkg::datareq_state_e       state,

    output logic [`CNT_BITS-1:0]           sent_cnt,
    output logic [`CNT_BITS-1:0]           done_cnt,
    output logic [`CNT_BITS-1:0]           null_cnt
);

    import dreq_pkg::*;

    // pulses can arrive before the FSM is ready for them (prefetch)
    logic sent_hold;
    logic null_hold;

    // hold flags consumed in this cycle
    logic sent_take;
    logic null_take;

    // request closes, by tag_done or a buffered null
    logic close_req;

    assign sent_take = (state == VALID) && sent_hold;
    assign null_take = (state == LAST) && null_hold;
    assign close_req = (state == LAST) && (ew_status.tag_done || null_hold);

    // tags sent should track fetches started, flagged in every LAST cycle
    assign tag_error = (state == LAST) && (sent_cnt != start_tag_cnt);

    //////////////////////////////////////////////////////////////////////
    // early pulse buffering
    //////////////////////////////////////////////////////////////////////

    // a pulse in the consuming cycle keeps the flag set
    always_ff @(posedge dreqclk or negedge resetn_dreqclk)
    begin
        if (!resetn_dreqclk)
        begin
            sent_hold <= 1'b0;
            null_hold <= 1'b0;
        end
        else
        begin
            sent_hold <= ew_status.tag_sent || (sent_hold && !sent_take);
            null_hold <= ew_status.tag_null || (null_hold && !null_take);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // protocol state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge dreqclk or negedge resetn_dreqclk)
    begin
        if (!resetn_dreqclk)
        begin
            state      <= IDLE;
            data_ready <= 1'b0;
            last_word  <= 1'b0;
            sent_cnt   <= '0;
            done_cnt   <= '0;
            null_cnt   <= '0;
        end
        else
        begin
            // single-cycle flag by default
            last_word <= 1'b0;

            case (state)
                // wait for the request to start
                IDLE:
                begin
                    if (event_start)
                    begin
                        state <= VALID;
                    end
                end

                // data goes out once the tag has been sent
                VALID:
                begin
                    if (sent_take)
                    begin
                        data_ready <= 1'b1;
                        sent_cnt   <= sent_cnt + `CNT_BITS'(1);
                        state      <= LAST;
                    end
                end

                // hold data_ready until done or an empty window
                LAST:
                begin
                    if (close_req)
                    begin
                        data_ready <= 1'b0;
                        last_word  <= 1'b1;
                        done_cnt   <= done_cnt + `CNT_BITS'(1);
                        if (null_take)
                        begin
                            null_cnt <= null_cnt + `CNT_BITS'(1);
                        end
                        state <= IDLE;
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    a_last_word_single : assert property (
        @(posedge dreqclk) disable iff (!resetn_dreqclk)
        last_word |=> !last_word
    )
    else $error("last_word held longer than one cycle");

    // last_word only closes a request that reached LAST
    a_last_word_from_last : assert property (
        @(posedge dreqclk) disable iff (!resetn_dreqclk)
        $rose(last_word) |-> ($past(state) == LAST)
    )
    else $error("last_word raised outside LAST");

endmodule

//--- hw/spill_offset_capture.sv
//////////////////////////////////////////////////////////////////////
// spill offset and full-window capture
// latches the event-window offset at spill start and samples the
// event window on the rising edge of dreq_full
//////////////////////////////////////////////////////////////////////

`include "dreq_params.svh"

module spill_offset_capture
(
    input  logic                          dreqclk,
    input  logic                          resetn_dreqclk,

    // pulse at the start of a new spill
    input  logic                          start_spill,

    // slow-control offset and its enable
    input  logic                          serial_en,
    input  logic [`SERIAL_OFFSET_BITS-1:0] serial_offset,

    // current event window from the heartbeat
    input  logic [`EVENT_TAG_BITS-1:0]    hb_event_window,

    // data-request buffer full level
    input  logic                          dreq_full,

    output dreq_pkg::offset_t             offset,
    output logic [`EVENT_TAG_BITS-1:0]    ewtag_dreq_full
);

    logic [`EVENT_TAG_BITS-1:0] offset_sel;
    logic [`EVENT_TAG_BITS-1:0] offset_q;
    logic                       offset_vld;

    // dreq_full history for edge detection
    logic                       full_q1;
    logic                       full_q2;

    // serial offset if enabled, else the window just before the current one
    assign offset_sel = serial_en ? `EVENT_TAG_BITS'(serial_offset)
                                  : hb_event_window - `EVENT_TAG_BITS'(1);

    //////////////////////////////////////////////////////////////////////
    // control flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge dreqclk or negedge resetn_dreqclk)
    begin
        if (!resetn_dreqclk)
        begin
            offset_vld <= 1'b0;
            full_q1    <= 1'b0;
            full_q2    <= 1'b0;
        end
        else
        begin
            // valid follows start_spill by exactly one cycle
            offset_vld <= start_spill;
            full_q1    <= dreq_full;
            full_q2    <= full_q1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // captured values
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge dreqclk)
    begin
        if (start_spill)
        begin
            offset_q <= offset_sel;
        end
        // window at the dreq_full rising edge
        if (full_q1 && !full_q2)
        begin
            ewtag_dreq_full <= hb_event_window;
        end
    end

    assign offset.valid        = offset_vld;
    assign offset.ewtag_offset = offset_q;

endmodule

//--- hw/dreq_diag.sv
//////////////////////////////////////////////////////////////////////
// data-request diagnostics
// counts rising edges of tag_valid and of the tag error flag
//////////////////////////////////////////////////////////////////////

`include "dreq_params.svh"

module dreq_diag
(
    input  logic                dreqclk,
    input  logic                resetn_dreqclk,

    // answer from the size store
    input  logic                tag_valid,

    // sent/started mismatch from the protocol FSM
    input  logic                tag_error,

    output dreq_pkg::diag_cnt_t diag_cnt
);

    // bit 0 tag_valid, bit 1 tag_error
    logic [1:0]            edge_in;
    logic [1:0]            edge_q1;
    logic [1:0]            edge_q2;
    logic [`DIAG_BITS-1:0] edge_cnt [2];

    assign edge_in = {tag_error, tag_valid};

    // inputs registered first, so a count moves two cycles after its edge
    always_ff @(posedge dreqclk or negedge resetn_dreqclk)
    begin
        if (!resetn_dreqclk)
        begin
            edge_q1 <= '0;
            edge_q2 <= '0;
            for (int i = 0; i < 2; i++)
            begin
                edge_cnt[i] <= '0;
            end
        end
        else
        begin
            edge_q1 <= edge_in;
            edge_q2 <= edge_q1;
            for (int i = 0; i < 2; i++)
            begin
                // rising edge of the registered input
                if (edge_q1[i] && !edge_q2[i])
                begin
                    edge_cnt[i] <= edge_cnt[i] + `DIAG_BITS'(1);
                end
            end
        end
    end

    assign diag_cnt.tag_valid_count = edge_cnt[0];
    assign diag_cnt.tag_error_count = edge_cnt[1];

endmodule

//--- hw/dreq_cntrl_top.sv
//////////////////////////////////////////////////////////////////////
// data-request controller top level
// fetch request, protocol FSM, spill offset capture and diagnostics
//////////////////////////////////////////////////////////////////////

`include "dreq_params.svh"

module dreq_cntrl_top
(
    input  logic                           dreqclk,
    input  logic                           resetn_dreqclk,

    input  logic                           start_fetch,
    input  logic                           tag_valid,
    input  logic                           event_start,
    input  logic                           start_spill,
    input  logic                           serial_en,
    input  logic                           dreq_full,
    input  logic [`EVENT_TAG_BITS-1:0]     event_window_fetch,
    input  logic [`EVENT_TAG_BITS-1:0]     hb_event_window,
    input  logic [`SERIAL_OFFSET_BITS-1:0] serial_offset,
    input  dreq_pkg::ew_status_t           ew_status,

    output logic                           tag_fetch,
    output logic                           data_ready,
    output logic                           last_word,
    output logic [`EVENT_TAG_BITS-1:0]     evt_tag_fetch,
    output logic [`EVENT_TAG_BITS-1:0]     ewtag_dreq_full,
    output dreq_pkg::offset_t              offset,
    output dreq_pkg::fetch_cnt_t           fetch_cnt,
    output dreq_pkg::diag_cnt_t            diag_cnt,
    output dreq_pkg::datareq_state_e       datareq_state
);

    // counters collected into fetch_cnt
    logic [`CNT_BITS-1:0] start_tag_cnt;
    logic [`CNT_BITS-1:0] sent_cnt;
    logic [`CNT_BITS-1:0] done_cnt;
    logic [`CNT_BITS-1:0] null_cnt;

    // FSM to diagnostics
    logic                 tag_error;

    assign fetch_cnt = '{start_tag_cnt: start_tag_cnt, tag_sent_cnt: sent_cnt,
                         tag_done_cnt: done_cnt, tag_null_cnt: null_cnt};

    // request to the size store
    fetch_tag_ctrl fetch_tag_ctrl_inst (
        .dreqclk            (dreqclk),
        .resetn_dreqclk     (resetn_dreqclk),
        .start_fetch        (start_fetch),
        .event_window_fetch (event_window_fetch),
        .tag_valid          (tag_valid),
        .tag_fetch          (tag_fetch),
        .evt_tag_fetch      (evt_tag_fetch),
        .start_tag_cnt      (start_tag_cnt)
    );

    // protocol towards the link
    datareq_fsm datareq_fsm_inst (
        .dreqclk        (dreqclk),
        .resetn_dreqclk (resetn_dreqclk),
        .event_start    (event_start),
        .ew_status      (ew_status),
        .start_tag_cnt  (start_tag_cnt),
        .data_ready     (data_ready),
        .last_word      (last_word),
        .tag_error      (tag_error),
        .state          (datareq_state),
        .sent_cnt       (sent_cnt),
        .done_cnt       (done_cnt),
        .null_cnt       (null_cnt)
    );

    spill_offset_capture spill_offset_capture_inst (
        .dreqclk         (dreqclk),
        .resetn_dreqclk  (resetn_dreqclk),
        .start_spill     (start_spill),
        .serial_en       (serial_en),
        .serial_offset   (serial_offset),
        .hb_event_window (hb_event_window),
        .dreq_full       (dreq_full),
        .offset          (offset),
        .ewtag_dreq_full (ewtag_dreq_full)
    );

    dreq_diag dreq_diag_inst (
        .dreqclk        (dreqclk),
        .resetn_dreqclk (resetn_dreqclk),
        .tag_valid      (tag_valid),
        .tag_error      (tag_error),
        .diag_cnt       (diag_cnt)
    );

endmodule

//--- test/tb_dreq_cntrl.sv
//////////////////////////////////////////////////////////////////////
// testbench for the data-request controller
// replays the command file against the DUT, checks every response
// and stops on the first mismatch or when the cycle budget runs out
//////////////////////////////////////////////////////////////////////

`include "dreq_params.svh"

module tb_dreq_cntrl;

    timeunit 1ns;
    timeprecision 1ps;

    import dreq_pkg::*;

    logic                           dreqclk = 1'b0;
    logic                           resetn_dreqclk;
    logic                           start_fetch;
    logic                           tag_valid;
    logic                           event_start;
    logic                           start_spill;
    logic                           serial_en;
    logic                           dreq_full;
    logic [`EVENT_TAG_BITS-1:0]     event_window_fetch;
    logic [`EVENT_TAG_BITS-1:0]     hb_event_window;
    logic [`SERIAL_OFFSET_BITS-1:0] serial_offset;
    ew_status_t                     ew_status;

    logic                           tag_fetch;
    logic                           data_ready;
    logic                           last_word;
    logic [`EVENT_TAG_BITS-1:0]     evt_tag_fetch;
    logic [`EVENT_TAG_BITS-1:0]     ewtag_dreq_full;
    offset_t                        offset;
    fetch_cnt_t                     fetch_cnt;
    diag_cnt_t                      diag_cnt;
    datareq_state_e                 datareq_state;

    // commands from the stim file, one entry per line
    string       op_q[$];
    logic [63:0] a_q[$];
    logic [63:0] b_q[$];
    logic [63:0] c_q[$];
    logic [63:0] d_q[$];

    integer seed = 67256;
    int     cycle_cnt = 0;
    int     cycle_limit = 0;
    // tag_valid pulses driven so far, the diag count must follow
    int     valid_pulses = 0;

    dreq_cntrl_top dreq_cntrl_top_inst (.*);

    always #5 dreqclk = ~dreqclk;

    // watchdog, armed once the command file has been read
    always @(posedge dreqclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout: no progress within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // command tasks, each starts and ends on a falling edge
    //////////////////////////////////////////////////////////////////////

    // request, random back-pressure, then the size store answers
    task automatic do_fetch(input logic [63:0] tag, input logic [63:0] exp_cnt);
        int gap;
        start_fetch        = 1'b1;
        event_window_fetch = tag[`EVENT_TAG_BITS-1:0];
        @(negedge dreqclk);
        start_fetch = 1'b0;
        check_value("tag_fetch", 64'(tag_fetch), 64'h1);
        check_value("evt_tag_fetch", 64'(evt_tag_fetch), tag);
        check_value("start_tag_cnt", 64'(fetch_cnt.start_tag_cnt), exp_cnt);
        gap = 1 + ($unsigned($random(seed)) % 8);
        repeat (gap)
        begin
            @(negedge dreqclk);
            check_value("tag_fetch", 64'(tag_fetch), 64'h1);
        end
        tag_valid = 1'b1;
        @(negedge dreqclk);
        tag_valid    = 1'b0;
        valid_pulses = valid_pulses + 1;
        check_value("tag_fetch", 64'(tag_fetch), 64'h0);
    endtask

    // one cycle after event_start the FSM is in VALID, also when it was there already
    task automatic do_start();
        event_start = 1'b1;
        @(negedge dreqclk);
        event_start = 1'b0;
        check_value("datareq_state", 64'(datareq_state), 64'(VALID));
        check_value("data_ready", 64'(data_ready), 64'h0);
    endtask

    // waits for last_word, which must last one cycle with data_ready low
    task automatic wait_close(input logic [63:0] exp_done, input logic [63:0] exp_null);
        while (last_word !== 1'b1)
        begin
            @(negedge dreqclk);
        end
        check_value("data_ready", 64'(data_ready), 64'h0);
        check_value("tag_done_cnt", 64'(fetch_cnt.tag_done_cnt), exp_done);
        check_value("tag_null_cnt", 64'(fetch_cnt.tag_null_cnt), exp_null);
        @(negedge dreqclk);
        check_value("last_word", 64'(last_word), 64'h0);
    endtask

    // close set means a buffered null ends the request by itself
    task automatic do_sent(input logic [63:0] close, input logic [63:0] exp_sent,
                           input logic [63:0] exp_done, input logic [63:0] exp_null);
        ew_status.tag_sent = 1'b1;
        @(negedge dreqclk);
        ew_status.tag_sent = 1'b0;
        while (data_ready !== 1'b1)
        begin
            @(negedge dreqclk);
        end
        check_value("tag_sent_cnt", 64'(fetch_cnt.tag_sent_cnt), exp_sent);
        if (close != 0)
        begin
            wait_close(exp_done, exp_null);
        end
    endtask

    task automatic do_done(input logic [63:0] exp_done, input logic [63:0] exp_null);
        // data_ready must still be up from the SENT
        check_value("data_ready", 64'(data_ready), 64'h1);
        ew_status.tag_done = 1'b1;
        @(negedge dreqclk);
        ew_status.tag_done = 1'b0;
        wait_close(exp_done, exp_null);
    endtask

    task automatic do_null();
        ew_status.tag_null = 1'b1;
        @(negedge dreqclk);
        ew_status.tag_null = 1'b0;
        check_value("data_ready", 64'(data_ready), 64'h0);
    endtask

    task automatic do_spill(input logic [63:0] en, input logic [63:0] serial,
                            input logic [63:0] hb, input logic [63:0] exp_offset);
        check_value("offset.valid", 64'(offset.valid), 64'h0);
        start_spill     = 1'b1;
        serial_en       = en[0];
        serial_offset   = serial[`SERIAL_OFFSET_BITS-1:0];
        hb_event_window = hb[`EVENT_TAG_BITS-1:0];
        @(negedge dreqclk);
        start_spill = 1'b0;
        check_value("offset.valid", 64'(offset.valid), 64'h1);
        check_value("offset.ewtag_offset", 64'(offset.ewtag_offset), exp_offset);
        @(negedge dreqclk);
        check_value("offset.valid", 64'(offset.valid), 64'h0);
        check_value("offset.ewtag_offset", 64'(offset.ewtag_offset), exp_offset);
    endtask

    // window moves every cycle, only the one at the second edge is kept
    task automatic do_full(input logic [63:0] hb_first, input logic [63:0] hb_second,
                           input logic [63:0] exp_window);
        dreq_full       = 1'b1;
        hb_event_window = hb_first[`EVENT_TAG_BITS-1:0];
        @(negedge dreqclk);
        hb_event_window = hb_second[`EVENT_TAG_BITS-1:0];
        @(negedge dreqclk);
        check_value("ewtag_dreq_full", 64'(ewtag_dreq_full), exp_window);
        dreq_full       = 1'b0;
        hb_event_window = hb_event_window + `EVENT_TAG_BITS'(5);
        repeat (3)
        begin
            @(negedge dreqclk);
        end
        check_value("ewtag_dreq_full", 64'(ewtag_dreq_full), exp_window);
    endtask

    task automatic do_wait(input logic [63:0] cycles, input logic [63:0] exp_err);
        repeat (cycles)
        begin
            @(negedge dreqclk);
        end
        check_value("tag_error_count", 64'(diag_cnt.tag_error_count), exp_err);
        check_value("tag_valid_count", 64'(diag_cnt.tag_valid_count), 64'(valid_pulses));
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int          fd;
        int          n;
        int          gap;
        string       line;
        string       op;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] d;

        resetn_dreqclk     = 1'b0;
        start_fetch        = 1'b0;
        tag_valid          = 1'b0;
        event_start        = 1'b0;
        start_spill        = 1'b0;
        serial_en          = 1'b0;
        dreq_full          = 1'b0;
        event_window_fetch = '0;
        hb_event_window    = '0;
        serial_offset      = '0;
        ew_status          = '0;

        fd = $fopen("test/dreq_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stim file test/dreq_stim.txt");
            stop_run();
        end
        // comment and blank lines are skipped
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line[0] == "#")
            begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d);
            if (n != 5)
            begin
                $display("stim line has %0d fields instead of 5: %s", n, line);
                stop_run();
            end
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
            d_q.push_back(d);
        end
        $fclose(fd);
        cycle_limit = 20 * op_q.size() + 200;

        repeat (16)
        begin
            @(posedge dreqclk);
        end
        @(negedge dreqclk);
        resetn_dreqclk = 1'b1;
        @(negedge dreqclk);
        check_value("tag_fetch", 64'(tag_fetch), 64'h0);
        check_value("data_ready", 64'(data_ready), 64'h0);
        check_value("last_word", 64'(last_word), 64'h0);
        check_value("offset.valid", 64'(offset.valid), 64'h0);
        check_value("fetch_cnt", 64'(fetch_cnt != '0), 64'h0);
        check_value("diag_cnt", 64'(diag_cnt), 64'h0);

        for (int i = 0; i < op_q.size(); i++)
        begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap)
            begin
                @(negedge dreqclk);
            end
            if (op_q[i] == "FETCH")
                do_fetch(a_q[i], b_q[i]);
            else if (op_q[i] == "START")
                do_start();
            else if (op_q[i] == "SENT")
                do_sent(a_q[i], b_q[i], c_q[i], d_q[i]);
            else if (op_q[i] == "DONE")
                do_done(a_q[i], b_q[i]);
            else if (op_q[i] == "NULL")
                do_null();
            else if (op_q[i] == "SPILL")
                do_spill(a_q[i], b_q[i], c_q[i], d_q[i]);
            else if (op_q[i] == "FULL")
                do_full(a_q[i], b_q[i], c_q[i]);
            else if (op_q[i] == "WAIT")
                do_wait(a_q[i], b_q[i]);
            else
            begin
                $display("unknown opcode %s in the stim file", op_q[i]);
                stop_run();
            end
        end

        $display("%0d commands checked in %0d cycles", op_q.size(), cycle_cnt);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- test/dreq_stim.txt
# opcode a b c d in hex: FETCH tag start_cnt, START state, SENT close sent done null,
# DONE done null, NULL, SPILL en serial hb offset, FULL hb0 hb1 window, WAIT cycles errors
FETCH 00000000a001 1 0 0
START 0 0 0 0
WAIT 0 0 0 0
START 1 0 0 0
SENT 0 1 0 0
DONE 1 0 0 0
WAIT 4 0 0 0
FETCH 00000000a002 2 0 0
NULL 0 0 0 0
START 1 0 0 0
SENT 1 2 2 1
WAIT 4 0 0 0
FETCH 123456789abc 3 0 0
FETCH fedcba987654 4 0 0
START 1 0 0 0
SENT 0 3 0 0
DONE 3 1 0 0
WAIT 4 1 0 0
SPILL 1 cafe0123 000000001000 cafe0123
SPILL 0 deadbeef 000000001000 000000000fff
SPILL 0 0 000000000000 ffffffffffff
FULL 000000002000 000000002001 000000002001 0
FULL 0000abcd0000 0000abcd0001 0000abcd0001 0
WAIT 2 1 0 0

//--- tb.f
+incdir+hw
hw/dreq_pkg.sv
hw/fetch_tag_ctrl.sv
hw/datareq_fsm.sv
hw/spill_offset_capture.sv
hw/dreq_diag.sv
hw/dreq_cntrl_top.sv
test/tb_dreq_cntrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data-request controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_dreq_cntrl \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_dreq_cntrl > sim.log 2>&1 || true
cat sim.log

grep -q "^Simulation finished: PASS$" sim.log \
    && echo "run passed" \
    || { echo "run failed, see sim.log"; exit 1; }
